// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// uncached on-chip sram window.
	localparam logic [31:0] sram_base  = 32'h0f00_0000;
	localparam logic [31:0] sram_limit = 32'h0f00_2000;

	localparam int mem_index_bits   = 9; // doubleword index, addr[11:3].
	localparam int mem_depth        = 1 << mem_index_bits;
	localparam int mem_read_latency = 2;

	localparam int cache_index_bits = 4;
	localparam int cache_lines      = 1 << cache_index_bits;
	localparam int cache_tag_bits   = 32 - cache_index_bits - 2;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_miss = 2'b10; // bit 1 flags the miss.

	// fetch unit states.
	localparam logic [2:0] st_idle     = 3'd0;
	localparam logic [2:0] st_lookup   = 3'd1;
	localparam logic [2:0] st_result   = 3'd2;
	localparam logic [2:0] st_mem      = 3'd3;
	localparam logic [2:0] st_mem_wait = 3'd4;
	localparam logic [2:0] st_refill   = 3'd5;
	localparam logic [2:0] st_done     = 3'd6;

	// one memory word, as a doubleword or as two instructions.
	typedef union packed {
		logic [63:0] dword;
		struct packed {
			logic [31:0] hi; // addr[2] set.
			logic [31:0] lo;
		} inst;
	} mem_word_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,
	output logic        lookup_valid,
	output logic [31:0] lookup_addr,
	input  logic        lookup_ready,
	input  logic        result_valid,
	input  logic [31:0] result_data,
	input  logic [1:0]  result_resp,
	output logic        result_ready,
	output logic        refill_valid,
	output logic [31:0] refill_addr,
	output logic [31:0] refill_data,
	input  logic        refill_ready,
	input  logic        done_valid,
	output logic        mem_valid,
	output logic [31:0] mem_addr,
	input  logic        mem_ready,
	input  logic        mem_rvalid,
	input  mem_word_t   mem_rdata,
	output logic [15:0] hit_count,
	output logic [15:0] miss_count
);
	logic [2:0]  state;
	logic [31:0] pc_q;
	logic        pc_sram;
	logic        hit;
	logic        miss;
	logic        mem_done;
	logic [31:0] mem_inst;

	function automatic logic in_sram(input logic [31:0] addr);
		return (addr >= sram_base) && (addr < sram_limit);
	endfunction

	assign pc_sram  = in_sram(pc_q);
	assign hit      = (state == st_result) && result_valid && !result_resp[1];
	assign miss     = (state == st_result) && result_valid && result_resp[1];
	assign mem_done = (state == st_mem_wait) && mem_rvalid;
	assign mem_inst = pc_q[2] ? mem_rdata.inst.hi : mem_rdata.inst.lo;

	assign lookup_valid = (state == st_lookup);
	assign lookup_addr  = pc_q;
	assign result_ready = 1'b1;
	assign mem_valid    = (state == st_mem);
	assign mem_addr     = pc_q;
	assign refill_valid = (state == st_refill);
	assign refill_addr  = pc_q;
	assign refill_data  = inst; // already holds the missed word.

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
			st_idle:     if (wb_valid) state <= in_sram(pc) ? st_mem : st_lookup;
			st_lookup:   if (lookup_ready) state <= st_result;
			st_result:   if (result_valid) state <= result_resp[1] ? st_mem : st_idle;
			st_mem:      if (mem_ready) state <= st_mem_wait;
			st_mem_wait: if (mem_rvalid) state <= pc_sram ? st_idle : st_refill;
			st_refill:   if (refill_ready) state <= st_done;
			st_done:     if (done_valid) state <= st_idle;
			default:     state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == st_idle) && wb_valid) begin
			pc_q <= pc;
		end
		if (hit) begin
			inst <= result_data;
		end else if (mem_done) begin
			inst <= mem_inst;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			idu_valid  <= 1'b0;
			hit_count  <= '0;
			miss_count <= '0;
		end else begin
			idu_valid <= hit || mem_done;
			if (hit) hit_count <= hit_count + 16'd1;
			if (miss) miss_count <= miss_count + 16'd1;
		end
	end

	// writeback must wait for the previous fetch, refill included.
	assert property (@(posedge clock) disable iff (!rst_n) wb_valid |-> state == st_idle)
		else $error("wb_valid raised while a fetch is in flight");

	assert property (@(posedge clock) disable iff (!rst_n)
		lookup_valid && !lookup_ready |=> lookup_valid && $stable(lookup_addr))
		else $error("lookup request dropped before acceptance");

endmodule

`default_nettype wire

// ==== verilog/inst_cache.sv ====
`default_nettype none

module inst_cache import fetch_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        lookup_valid,
	input  logic [31:0] lookup_addr,
	output logic        lookup_ready,
	output logic        result_valid,
	output logic [31:0] result_data,
	output logic [1:0]  result_resp,
	input  logic        result_ready,
	input  logic        refill_valid,
	input  logic [31:0] refill_addr,
	input  logic [31:0] refill_data,
	output logic        refill_ready,
	output logic        done_valid
);
	logic [cache_lines-1:0]      line_valid;
	logic [cache_tag_bits-1:0]   tag_arr [cache_lines];
	logic [31:0]                 data_arr [cache_lines];
	logic [cache_index_bits-1:0] lk_idx;
	logic [cache_tag_bits-1:0]   lk_tag;
	logic [cache_index_bits-1:0] rf_idx;
	logic [cache_tag_bits-1:0]   rf_tag;
	logic                        lk_fire;
	logic                        rf_fire;

	assign lk_idx = lookup_addr[cache_index_bits+1:2];
	assign lk_tag = lookup_addr[31:cache_index_bits+2];
	assign rf_idx = refill_addr[cache_index_bits+1:2];
	assign rf_tag = refill_addr[31:cache_index_bits+2];

	assign lookup_ready = !result_valid; // busy while a result is pending.
	assign refill_ready = !done_valid;
	assign lk_fire      = lookup_valid && lookup_ready;
	assign rf_fire      = refill_valid && refill_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			line_valid   <= '0;
			result_valid <= 1'b0;
			done_valid   <= 1'b0;
		end else begin
			result_valid <= lk_fire || (result_valid && !result_ready);
			done_valid   <= rf_fire;
			if (rf_fire) line_valid[rf_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rf_fire) begin
			tag_arr[rf_idx]  <= rf_tag;
			data_arr[rf_idx] <= refill_data;
		end
		if (lk_fire) begin
			result_data <= data_arr[lk_idx];
			result_resp <= (line_valid[lk_idx] && (tag_arr[lk_idx] == lk_tag)) ?
				resp_okay : resp_miss;
		end
	end

	// requester keeps result_ready high, so results are single pulses.
	assert property (@(posedge clock) disable iff (!rst_n) result_valid |=> !result_valid)
		else $error("result_valid held for two cycles");

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import fetch_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        load_valid,
	input  logic [31:0] load_addr,
	input  logic [63:0] load_wdata,
	input  logic [7:0]  load_wstrb,
	output logic        load_ready,
	input  logic        fetch_valid,
	input  logic [31:0] fetch_addr,
	output logic        fetch_ready,
	output logic        fetch_rvalid,
	input  logic        data_valid,
	input  logic [31:0] data_addr,
	output logic        data_ready,
	output logic        data_rvalid,
	output mem_word_t   rdata,
	output logic        mem_req,
	output logic        mem_we,
	output logic [31:0] mem_addr,
	output logic [63:0] mem_wdata,
	output logic [7:0]  mem_wstrb,
	input  logic        mem_rvalid,
	input  logic [63:0] mem_rdata
);
	logic busy;   // read outstanding.
	logic owner;  // 1 = data port owns it.
	logic rr;     // 1 = data wins a tie.
	logic free;
	logic grant_load;
	logic grant_fetch;
	logic grant_data;

	assign free        = !busy || mem_rvalid;
	assign grant_load  = free && load_valid;
	assign grant_fetch = free && !load_valid && fetch_valid && (!data_valid || !rr);
	assign grant_data  = free && !load_valid && data_valid && (!fetch_valid || rr);

	assign load_ready  = grant_load;
	assign fetch_ready = grant_fetch;
	assign data_ready  = grant_data;

	assign mem_req   = grant_load || grant_fetch || grant_data;
	assign mem_we    = grant_load;
	assign mem_addr  = grant_load ? load_addr : (grant_data ? data_addr : fetch_addr);
	assign mem_wdata = load_wdata;
	assign mem_wstrb = load_wstrb;

	assign rdata        = mem_rdata;
	assign fetch_rvalid = mem_rvalid && busy && !owner;
	assign data_rvalid  = mem_rvalid && busy && owner;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			owner <= 1'b0;
			rr    <= 1'b0;
		end else begin
			busy <= grant_fetch || grant_data || (busy && !mem_rvalid);
			if (grant_fetch || grant_data) begin
				owner <= grant_data;
				rr    <= grant_fetch; // other reader goes next.
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({grant_load, grant_fetch, grant_data}))
		else $error("more than one memory grant");

	// memory answers only reads this arbiter has issued.
	assert property (@(posedge clock) disable iff (!rst_n) mem_rvalid |-> busy)
		else $error("memory read data with no read outstanding");

endmodule

`default_nettype wire

// ==== verilog/backing_mem.sv ====
`default_nettype none

module backing_mem import fetch_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        req,
	input  logic        we,
	input  logic [31:0] addr,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	output logic        rvalid,
	output logic [63:0] rdata
);
	logic [63:0]                 mem [mem_depth];
	logic [mem_index_bits-1:0]   idx;
	logic [mem_index_bits-1:0]   rd_idx;
	logic                        rd_go;
	logic [mem_read_latency-1:0] vld_pipe;
	logic [63:0]                 dat_pipe [mem_read_latency];

	assign idx = addr[mem_index_bits+2:3]; // same index in every region.

	always_ff @(posedge clock) begin
		if (req && we) begin
			for (int b = 0; b < 8; b++) begin
				if (wstrb[b]) mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

	// request register, then the data stages.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_go    <= 1'b0;
			vld_pipe <= '0;
		end else begin
			rd_go       <= req && !we;
			vld_pipe[0] <= rd_go;
			for (int i = 1; i < mem_read_latency; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		rd_idx      <= idx;
		dat_pipe[0] <= mem[rd_idx];
		for (int i = 1; i < mem_read_latency; i++) begin
			dat_pipe[i] <= dat_pipe[i-1];
		end
	end

	assign rvalid = vld_pipe[mem_read_latency-1];
	assign rdata  = dat_pipe[mem_read_latency-1];

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        wb_valid,
	input  logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,
	output logic [15:0] hit_count,
	output logic [15:0] miss_count,
	input  logic        load_valid,
	input  logic [31:0] load_addr,
	input  logic [63:0] load_wdata,
	input  logic [7:0]  load_wstrb,
	output logic        load_ready,
	input  logic        data_valid,
	input  logic [31:0] data_addr,
	output logic        data_ready,
	output logic        data_rvalid,
	output logic [63:0] data_rdata
);
	logic        lookup_valid, lookup_ready, result_valid, result_ready;
	logic        refill_valid, refill_ready, done_valid;
	logic [31:0] lookup_addr, result_data, refill_addr, refill_data;
	logic [1:0]  result_resp;
	logic        fetch_valid, fetch_ready, fetch_rvalid;
	logic [31:0] fetch_addr, mem_addr;
	logic        mem_req, mem_we, mem_rvalid;
	logic [63:0] mem_wdata, mem_rdata;
	logic [7:0]  mem_wstrb;
	mem_word_t   rd_word;

	assign data_rdata = rd_word.dword; // data port sees the whole word.

	fetch_unit fetch_unit_inst (
		.clock, .rst_n, .wb_valid, .pc, .inst, .idu_valid,
		.lookup_valid, .lookup_addr, .lookup_ready,
		.result_valid, .result_data, .result_resp, .result_ready,
		.refill_valid, .refill_addr, .refill_data, .refill_ready, .done_valid,
		.mem_valid(fetch_valid),
		.mem_addr(fetch_addr),
		.mem_ready(fetch_ready),
		.mem_rvalid(fetch_rvalid),
		.mem_rdata(rd_word),
		.hit_count, .miss_count
	);

	inst_cache inst_cache_inst (
		.clock, .rst_n,
		.lookup_valid, .lookup_addr, .lookup_ready,
		.result_valid, .result_data, .result_resp, .result_ready,
		.refill_valid, .refill_addr, .refill_data, .refill_ready, .done_valid
	);

	mem_arbiter mem_arbiter_inst (
		.clock, .rst_n,
		.load_valid, .load_addr, .load_wdata, .load_wstrb, .load_ready,
		.fetch_valid, .fetch_addr, .fetch_ready, .fetch_rvalid,
		.data_valid, .data_addr, .data_ready, .data_rvalid,
		.rdata(rd_word),
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb,
		.mem_rvalid, .mem_rdata
	);

	backing_mem backing_mem_inst (
		.clock, .rst_n,
		.req(mem_req),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.wstrb(mem_wstrb),
		.rvalid(mem_rvalid),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`default_nettype none

module fetch_tb import fetch_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 200;

	logic        clock;
	logic        rst_n;
	logic        wb_valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        idu_valid;
	logic [15:0] hit_count;
	logic [15:0] miss_count;
	logic        load_valid;
	logic [31:0] load_addr;
	logic [63:0] load_wdata;
	logic [7:0]  load_wstrb;
	logic        load_ready;
	logic        data_valid;
	logic [31:0] data_addr;
	logic        data_ready;
	logic        data_rvalid;
	logic [63:0] data_rdata;

	logic [63:0] shadow [mem_depth]; // reference copy of memory.
	int          errors;
	int          checks;

	fetch_top fetch_top_inst (
		.clock, .rst_n, .wb_valid, .pc, .inst, .idu_valid, .hit_count, .miss_count,
		.load_valid, .load_addr, .load_wdata, .load_wstrb, .load_ready,
		.data_valid, .data_addr, .data_ready, .data_rvalid, .data_rdata
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic require_arrival(input string what, input bit seen);
		checks++;
		assert (seen) else begin
			$display("%s did not arrive within %0d cycles", what, timeout_cycles);
			errors++;
		end
	endtask

	// half of the stored doubleword picked by address bit 2.
	function automatic logic [31:0] expected_inst(input logic [31:0] addr);
		logic [63:0] dw;
		dw = shadow[addr[11:3]];
		return addr[2] ? dw[63:32] : dw[31:0];
	endfunction

	task automatic load_word(input logic [31:0] addr, input logic [63:0] value);
		bit seen;
		seen = 1'b0;
		@(posedge clock);
		load_valid <= 1'b1;
		load_addr  <= addr;
		load_wdata <= value;
		load_wstrb <= 8'hff;
		for (int n = 0; n < timeout_cycles && !seen; n++) begin
			@(negedge clock);
			seen = load_ready;
			if (!seen) @(posedge clock);
		end
		@(posedge clock); // write lands on this edge.
		load_valid <= 1'b0;
		require_arrival("load_ready", seen);
		shadow[addr[11:3]] = value;
	endtask

	task automatic read_data(input logic [31:0] addr);
		bit granted;
		bit returned;
		granted  = 1'b0;
		returned = 1'b0;
		@(posedge clock);
		data_valid <= 1'b1;
		data_addr  <= addr;
		for (int n = 0; n < timeout_cycles && !granted; n++) begin
			@(negedge clock);
			granted = data_ready;
			if (!granted) @(posedge clock);
		end
		@(posedge clock);
		data_valid <= 1'b0;
		require_arrival("data_ready", granted);
		for (int n = 0; n < timeout_cycles && !returned; n++) begin
			@(negedge clock);
			returned = data_rvalid;
			if (!returned) @(posedge clock);
		end
		require_arrival("data_rvalid", returned);
		if (returned) check_value("data_rdata", data_rdata, shadow[addr[11:3]]);
	endtask

	// latency counts edges from the wb_valid drive edge to idu_valid.
	task automatic fetch_inst(input logic [31:0] addr, output int latency);
		bit done;
		done = 1'b0;
		@(posedge clock);
		wb_valid <= 1'b1;
		pc       <= addr;
		@(posedge clock);
		wb_valid <= 1'b0;
		latency = 1;
		for (int n = 0; n < timeout_cycles && !done; n++) begin
			@(negedge clock);
			done = idu_valid;
			if (!done) begin
				@(posedge clock);
				latency++;
			end
		end
		require_arrival("idu_valid", done);
		if (done) check_value("inst", 64'(inst), 64'(expected_inst(addr)));
		repeat (2) @(posedge clock); // refill takes two more edges.
	endtask

	task automatic load_and_read_back();
		logic [63:0] value;
		for (int i = 0; i < mem_depth; i++) begin
			value = {$urandom, $urandom};
			load_word(32'h2000_0000 + 32'(i * 8), value);
		end
		for (int i = 0; i < mem_depth; i++) begin
			read_data(32'h2000_0000 + 32'(i * 8));
		end
	endtask

	task automatic sram_window_fetches();
		logic [31:0] addrs [6];
		logic [15:0] hits;
		logic [15:0] misses;
		int          lat;
		addrs = '{32'h0f00_0000, 32'h0f00_0004, 32'h0f00_0128,
			32'h0f00_012c, 32'h0f00_1ff8, 32'h0f00_1ffc};
		hits   = hit_count;
		misses = miss_count;
		foreach (addrs[i]) fetch_inst(addrs[i], lat);
		check_value("hit_count", 64'(hit_count), 64'(hits)); // window bypasses the cache.
		check_value("miss_count", 64'(miss_count), 64'(misses));
	endtask

	task automatic first_miss_fetches();
		logic [15:0] misses;
		int          lat;
		for (int i = 0; i < 8; i++) begin
			misses = miss_count;
			fetch_inst(32'h8000_0000 + 32'(i * 4), lat);
			check_value("miss_count", 64'(miss_count), 64'(misses + 16'd1));
		end
	endtask

	task automatic repeat_hit_fetches();
		logic [15:0] hits;
		int          lat;
		for (int i = 0; i < 8; i++) begin
			hits = hit_count;
			fetch_inst(32'h8000_0000 + 32'(i * 4), lat);
			check_value("hit_count", 64'(hit_count), 64'(hits + 16'd1));
			check_value("hit latency", 64'(lat), 64'd3);
		end
	endtask

	// index 8 under two tags, so each access evicts the other.
	task automatic alternating_conflicts();
		logic [15:0] hits;
		logic [15:0] misses;
		int          lat;
		for (int i = 0; i < 6; i++) begin
			hits   = hit_count;
			misses = miss_count;
			fetch_inst((i % 2 == 1) ? 32'h8000_0820 : 32'h8000_0020, lat);
			check_value("miss_count", 64'(miss_count), 64'(misses + 16'd1));
			check_value("hit_count", 64'(hit_count), 64'(hits));
		end
	endtask

	task automatic data_reads_during_misses();
		logic [15:0] misses;
		int          lat;
		int unsigned pick;
		misses = miss_count;
		fork
			for (int i = 0; i < 8; i++) begin
				fetch_inst(32'h9000_0000 + 32'(i * 4), lat);
			end
			for (int j = 0; j < 16; j++) begin
				pick = $urandom % mem_depth;
				read_data(32'h3000_0000 + 32'(pick * 8));
			end
		join
		check_value("miss_count", 64'(miss_count), 64'(misses + 16'd8));
	endtask

	initial begin
		void'($urandom(32'h9113));
		errors     = 0;
		checks     = 0;
		rst_n      = 1'b0;
		wb_valid   = 1'b0;
		pc         = '0;
		load_valid = 1'b0;
		load_addr  = '0;
		load_wdata = '0;
		load_wstrb = '0;
		data_valid = 1'b0;
		data_addr  = '0;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_value("idu_valid", 64'(idu_valid), 64'd0);
		check_value("hit_count", 64'(hit_count), 64'd0);
		check_value("miss_count", 64'(miss_count), 64'd0);
		check_value("load_ready", 64'(load_ready), 64'd0);
		check_value("data_ready", 64'(data_ready), 64'd0);
		check_value("data_rvalid", 64'(data_rvalid), 64'd0);
		load_and_read_back();
		sram_window_fetches();
		first_miss_fetches();
		repeat_hit_fetches();
		alternating_conflicts();
		data_reads_during_misses();
		repeat (4) @(posedge clock);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_sys.f ====
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/inst_cache.sv
verilog/mem_arbiter.sv
verilog/backing_mem.sv
verilog/fetch_top.sv
dv/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module fetch_tb \
	-f fetch_sys.f \
	-o fetch_sim

./obj_dir/fetch_sim | tee "$log"

if grep -q -F '** FAIL **' "$log"; then
	echo "simulation failed, see $log"
	exit 1
fi
echo "simulation finished without failures"
